// File: include/board_macros.svh
`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

// ============================================================
// reset stretch
// ============================================================
`define BOARD_RST_HOLD_CYCLES 16            // clocks of reset after both inputs release

// ============================================================
// register bus
// ============================================================
`define BOARD_DATA_W 32                     // bus data width
`define BOARD_ADDR_W 4                      // bus address width

// register map
`define BOARD_ADDR_LED (`BOARD_ADDR_W'(0))  // led export word
`define BOARD_ADDR_SW  (`BOARD_ADDR_W'(1))  // synced switches, read only
`define BOARD_ADDR_IRQ (`BOARD_ADDR_W'(2))  // sticky interrupt status

`define BOARD_BAD_RDATA 32'hdead_c0de       // read value of any unmapped address

`endif

// File: source/board_pkg.sv
package board_pkg;

    // active-low segment pattern with segment a in bit 0
    // bit 6 is segment g
    typedef logic [6:0] seg_t;

    // the led export word
    // same 32 bits drive the lamps and the eight hex digits
    typedef union packed {
        // hex digit view
        logic [7:0][3:0] digits;       // digit 0 in bits 3..0

        // lamp view
        struct packed {
            logic [4:0]  unused;       // no lamps up here
            logic [17:0] ledr;         // red lamps, bits 26..9
            logic [8:0]  ledg;         // green lamps, bits 8..0
        } lamps;
    } led_word_u;

endpackage

// File: source/bus_pkg.sv
`include "board_macros.svh"

package bus_pkg;

    // register addresses on the plain strobe bus
    // anything else reads back as the bad-data word
    typedef enum logic [`BOARD_ADDR_W-1:0] {
        REG_LED = `BOARD_ADDR_LED,  // r/w led export word
        REG_SW  = `BOARD_ADDR_SW,   // ro switches after the synchronizer
        REG_IRQ = `BOARD_ADDR_IRQ   // bit 0 status, write 1 to clear
    } reg_addr_e;

endpackage

// File: source/clk_ctrl.sv
`timescale 1ns/1ps
`include "board_macros.svh"

module clk_ctrl (
    input  logic clk,
    input  logic arst_n,     // board reset, stands in for pll lock
    input  logic rst_key_n,  // push key 0, low while pressed
    output logic rst_n       // stretched system reset
);

    localparam int HOLD  = `BOARD_RST_HOLD_CYCLES;
    localparam int CNT_W = $clog2(HOLD + 1);  // room to reach HOLD itself

    logic             in_n;   // both reset sources released
    logic [CNT_W-1:0] cnt;    // edges seen since release
    logic             rst_q;

    assign in_n = arst_n & rst_key_n;

    // ============================================================
    // hold counter
    // ============================================================
    // either source low clears everything at once
    // rst_q goes high on the HOLD-th edge after release
    always_ff @(posedge clk or negedge in_n) begin
        if (!in_n) begin
            cnt   <= '0;
            rst_q <= 1'b0;
        end else if (!rst_q) begin
            cnt   <= cnt + 1'b1;
            rst_q <= (cnt == CNT_W'(HOLD - 1));  // last edge of the stretch
        end
    end

    assign rst_n = rst_q;

    // out of reset only with both sources up now and a full stretch back
    a_rst_follows_inputs: assert property (@(posedge clk)
        rst_n |-> in_n && $past(in_n, HOLD));

endmodule

// File: source/io_regs.sv
`timescale 1ns/1ps
`include "board_macros.svh"

module io_regs (
    input  logic                                  clk,
    input  logic                                  rst_n,      // from clk_ctrl
    input  logic                                  bus_wr,     // one-cycle write strobe
    input  logic                                  bus_rd,     // one-cycle read strobe
    input  logic [$bits(bus_pkg::reg_addr_e)-1:0] bus_addr,
    input  logic [`BOARD_DATA_W-1:0]              bus_wdata,
    input  logic [17:0]                           sw,         // raw board switches
    input  logic                                  irq_in,     // sensor interrupt
    output logic [`BOARD_DATA_W-1:0]              bus_rdata,  // valid the edge after bus_rd
    output board_pkg::led_word_u                  led_word,
    output logic                                  irq
);

    import board_pkg::*;
    import bus_pkg::*;

    reg_addr_e                addr;
    logic                     wr_led;
    logic                     wr_irq;
    led_word_u                led_q;
    logic [17:0]              sw_meta;   // first sync stage
    logic [17:0]              sw_sync;   // second sync stage, safe to use
    logic                     irq_set;
    logic                     irq_clr;
    logic                     irq_q;
    logic [`BOARD_DATA_W-1:0] rd_mux;

    // ============================================================
    // address decode
    // ============================================================
    assign addr   = reg_addr_e'(bus_addr);
    assign wr_led = bus_wr && (addr == REG_LED);
    assign wr_irq = bus_wr && (addr == REG_IRQ);

    // led export word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            led_q <= '0;                     // lamps off, all digits show 0
        end else if (wr_led) begin
            led_q <= led_word_u'(bus_wdata);
        end
    end

    // two-flop switch synchronizer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sw_meta <= '0;
            sw_sync <= '0;
        end else begin
            sw_meta <= sw;
            sw_sync <= sw_meta;
        end
    end

    // ============================================================
    // interrupt status
    // ============================================================
    assign irq_set = irq_in && sw_sync[1];   // switch 1 enables the sensor irq
    assign irq_clr = wr_irq && bus_wdata[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= irq_set || (irq_q && !irq_clr);  // a new set beats a clear
        end
    end

    // ============================================================
    // read path
    // ============================================================
    always_comb begin
        case (addr)
            REG_LED: rd_mux = led_q;
            REG_SW:  rd_mux = `BOARD_DATA_W'(sw_sync);  // zero-extended
            REG_IRQ: rd_mux = `BOARD_DATA_W'(irq_q);
            default: rd_mux = `BOARD_BAD_RDATA;         // unmapped
        endcase
    end

    // fixed one-cycle latency, holds until the next read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus_rdata <= '0;
        end else if (bus_rd) begin
            bus_rdata <= rd_mux;
        end
    end

    assign led_word = led_q;
    assign irq      = irq_q;

    // bus master must never strobe both directions at once
    a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
        !(bus_wr && bus_rd));

    // irq rising means a gated set was seen one edge earlier
    a_irq_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(irq) |-> $past(irq_in && sw_sync[1]));

endmodule

// File: source/seg7_lut_8.sv
`timescale 1ns/1ps

module seg7_lut_8 (
    input  board_pkg::led_word_u led_word,
    output board_pkg::seg_t      hex0,  // rightmost digit
    output board_pkg::seg_t      hex1,
    output board_pkg::seg_t      hex2,
    output board_pkg::seg_t      hex3,
    output board_pkg::seg_t      hex4,
    output board_pkg::seg_t      hex5,
    output board_pkg::seg_t      hex6,
    output board_pkg::seg_t      hex7   // leftmost digit
);

    import board_pkg::*;

    // nibble to active-low glyph, bit order g f e d c b a
    function automatic seg_t hex_glyph(input logic [3:0] nib);
        case (nib)
            4'h0: hex_glyph = 7'b1000000;
            4'h1: hex_glyph = 7'b1111001;
            4'h2: hex_glyph = 7'b0100100;
            4'h3: hex_glyph = 7'b0110000;
            4'h4: hex_glyph = 7'b0011001;
            4'h5: hex_glyph = 7'b0010010;
            4'h6: hex_glyph = 7'b0000010;
            4'h7: hex_glyph = 7'b1111000;
            4'h8: hex_glyph = 7'b0000000;
            4'h9: hex_glyph = 7'b0011000;  // no bottom bar
            4'ha: hex_glyph = 7'b0001000;
            4'hb: hex_glyph = 7'b0000011;  // lower case b
            4'hc: hex_glyph = 7'b1000110;
            4'hd: hex_glyph = 7'b0100001;  // lower case d
            4'he: hex_glyph = 7'b0000110;
            4'hf: hex_glyph = 7'b0001110;
        endcase
    endfunction

    // one glyph per nibble of the digit view
    assign hex0 = hex_glyph(led_word.digits[0]);
    assign hex1 = hex_glyph(led_word.digits[1]);
    assign hex2 = hex_glyph(led_word.digits[2]);
    assign hex3 = hex_glyph(led_word.digits[3]);
    assign hex4 = hex_glyph(led_word.digits[4]);
    assign hex5 = hex_glyph(led_word.digits[5]);
    assign hex6 = hex_glyph(led_word.digits[6]);
    assign hex7 = hex_glyph(led_word.digits[7]);

endmodule

// File: source/soc_toplevel.sv
`timescale 1ns/1ps
`include "board_macros.svh"

module soc_toplevel (
    input  logic                     clk,        // system clock
    input  logic                     arst_n,     // stands in for pll lock
    input  logic [3:0]               key,        // push keys, key 0 is reset
    input  logic [17:0]              sw,
    input  logic                     irq_in,     // sensor interrupt pin
    input  logic                     bus_wr,
    input  logic                     bus_rd,
    input  logic [`BOARD_ADDR_W-1:0] bus_addr,
    input  logic [`BOARD_DATA_W-1:0] bus_wdata,
    output logic [`BOARD_DATA_W-1:0] bus_rdata,
    output logic                     irq,
    output logic [17:0]              ledr,
    output logic [8:0]               ledg,
    output logic [6:0]               hex0,
    output logic [6:0]               hex1,
    output logic [6:0]               hex2,
    output logic [6:0]               hex3,
    output logic [6:0]               hex4,
    output logic [6:0]               hex5,
    output logic [6:0]               hex6,
    output logic [6:0]               hex7
);

    import board_pkg::*;

    logic      rst_n;     // stretched system reset
    led_word_u led_word;  // led export word

    clk_ctrl u_clk_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .rst_key_n (key[0]),
        .rst_n     (rst_n)
    );

    io_regs u_io_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_wr    (bus_wr),
        .bus_rd    (bus_rd),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .sw        (sw),
        .irq_in    (irq_in),
        .bus_rdata (bus_rdata),
        .led_word  (led_word),
        .irq       (irq)
    );

    seg7_lut_8 u_segs (
        .led_word (led_word),
        .hex0     (hex0),
        .hex1     (hex1),
        .hex2     (hex2),
        .hex3     (hex3),
        .hex4     (hex4),
        .hex5     (hex5),
        .hex6     (hex6),
        .hex7     (hex7)
    );

    // lamps straight from the lamp view
    assign ledr = led_word.lamps.ledr;
    assign ledg = led_word.lamps.ledg;

endmodule

// File: test/soc_checker.sv
`timescale 1ns/1ps
`include "board_macros.svh"

module soc_checker (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     key0,       // reset key
    input  logic                     bus_wr,
    input  logic [`BOARD_ADDR_W-1:0] bus_addr,
    input  logic [`BOARD_DATA_W-1:0] bus_wdata,
    input  logic [`BOARD_DATA_W-1:0] bus_rdata,
    input  logic                     irq,
    input  logic [17:0]              ledr,
    input  logic [8:0]               ledg,
    input  logic [55:0]              hex_all,    // hex7 down to hex0
    input  logic                     chk_rd,     // row is a checked read
    input  logic [`BOARD_DATA_W-1:0] exp_rdata,
    input  logic [127:0]             test_name,
    output int                       err_cnt
);

    import board_pkg::*;

    // standard active-low hex glyphs, segment a in bit 0
    localparam seg_t GLYPH [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h18, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
    };

    logic        src_rst_n;   // low while either reset source is low
    logic [31:0] led_model;   // last led word written since reset
    logic        rd_pend;     // read data due at this negedge
    logic [31:0] rd_exp;
    logic [3:0]  rd_addr;
    int          errs = 0;

    assign src_rst_n = arst_n & key0;
    assign err_cnt   = errs;

    function automatic logic [55:0] segs_for(input logic [31:0] w);
        logic [55:0] s;
        for (int i = 0; i < 8; i++) begin
            s[7*i +: 7] = GLYPH[w[4*i +: 4]];  // nibble i drives digit i
        end
        return s;
    endfunction

    task automatic report_mismatch(input string what, input logic [63:0] exp,
                                   input logic [63:0] act);
        errs++;
        $display("CHECK FAILED %0s %0s: expected %0h actual %0h at %0t",
                 test_name, what, exp, act, $time);
    endtask

    // ============================================================
    // reference model
    // ============================================================
    always @(posedge clk or negedge src_rst_n) begin
        if (!src_rst_n) begin
            led_model <= '0;  // key or board reset wipes the word at once
        end else if (bus_wr && bus_addr == `BOARD_ADDR_LED) begin
            led_model <= bus_wdata;
        end
    end

    // read data lands one edge after the strobe
    always @(posedge clk) begin
        rd_pend <= chk_rd;
        if (chk_rd) begin
            rd_exp  <= exp_rdata;
            rd_addr <= bus_addr;
        end
    end

    // ============================================================
    // compare at the falling edge, outputs are settled there
    // ============================================================
    always @(negedge clk) begin
        if (ledg !== led_model[8:0])
            report_mismatch("ledg", 64'(led_model[8:0]), 64'(ledg));
        if (ledr !== led_model[26:9])
            report_mismatch("ledr", 64'(led_model[26:9]), 64'(ledr));
        if (hex_all !== segs_for(led_model))
            report_mismatch("hex digits", 64'(segs_for(led_model)), 64'(hex_all));
        if (rd_pend) begin
            if (bus_rdata !== rd_exp)
                report_mismatch("bus_rdata", 64'(rd_exp), 64'(bus_rdata));
            // status bit and pin must agree
            if (rd_addr == `BOARD_ADDR_IRQ && irq !== rd_exp[0])
                report_mismatch("irq pin", 64'(rd_exp[0]), 64'(irq));
        end
    end

endmodule

// File: test/tb_soc_toplevel.sv
`timescale 1ns/1ps
`include "board_macros.svh"

module tb_soc_toplevel;

    import bus_pkg::*;

    typedef enum logic [2:0] {OP_WR, OP_RD, OP_IDLE, OP_SW, OP_IRQ, OP_KEY} op_e;

    logic        clk;
    logic        arst_n;
    logic [3:0]  key;
    logic [17:0] sw;
    logic        irq_in;
    logic        bus_wr;
    logic        bus_rd;
    logic [3:0]  bus_addr;
    logic [31:0] bus_wdata;
    logic [31:0] bus_rdata;
    logic        irq;
    logic [17:0] ledr;
    logic [8:0]  ledg;
    logic [6:0]  hex0;
    logic [6:0]  hex1;
    logic [6:0]  hex2;
    logic [6:0]  hex3;
    logic [6:0]  hex4;
    logic [6:0]  hex5;
    logic [6:0]  hex6;
    logic [6:0]  hex7;
    logic        chk_rd;
    logic [31:0] exp_rdata;
    logic [127:0] cur_name;   // row name shown in error lines
    int          errors;
    logic [31:0] lfsr;

    // stimulus table
    op_e          op_tab   [64];
    logic [3:0]   addr_tab [64];
    logic [31:0]  data_tab [64];
    logic [31:0]  exp_tab  [64];
    logic [127:0] name_tab [64];
    int           n_rows;

    always #5 clk = ~clk;  // 10 ns period

    soc_toplevel uut (
        .clk(clk), .arst_n(arst_n), .key(key), .sw(sw), .irq_in(irq_in),
        .bus_wr(bus_wr), .bus_rd(bus_rd), .bus_addr(bus_addr), .bus_wdata(bus_wdata),
        .bus_rdata(bus_rdata), .irq(irq), .ledr(ledr), .ledg(ledg),
        .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3),
        .hex4(hex4), .hex5(hex5), .hex6(hex6), .hex7(hex7)
    );

    soc_checker u_chk (
        .clk(clk), .arst_n(arst_n), .key0(key[0]), .bus_wr(bus_wr),
        .bus_addr(bus_addr), .bus_wdata(bus_wdata), .bus_rdata(bus_rdata),
        .irq(irq), .ledr(ledr), .ledg(ledg),
        .hex_all({hex7, hex6, hex5, hex4, hex3, hex2, hex1, hex0}),
        .chk_rd(chk_rd), .exp_rdata(exp_rdata), .test_name(cur_name),
        .err_cnt(errors)
    );

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic next_lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        for (int b = 0; b < 32; b++) begin
            w[b] = next_lfsr_bit();  // one step per bit
        end
        return w;
    endfunction

    task automatic add_row(input op_e op, input logic [3:0] addr, input logic [31:0] data,
                           input logic [31:0] exp, input logic [127:0] name);
        op_tab[n_rows]   = op;
        addr_tab[n_rows] = addr;
        data_tab[n_rows] = data;
        exp_tab[n_rows]  = exp;
        name_tab[n_rows] = name;
        n_rows++;
    endtask

    // ============================================================
    // table contents
    // ============================================================
    task automatic build_table();
        logic [31:0] w;
        add_row(OP_RD, REG_IRQ, '0, '0, "reset_irq");
        add_row(OP_RD, REG_LED, '0, '0, "reset_led");
        add_row(OP_WR, REG_LED, 32'h1234_5678, '0, "led_fixed");
        add_row(OP_RD, REG_LED, '0, 32'h1234_5678, "led_fixed_rd");
        add_row(OP_WR, REG_LED, 32'hffff_ffff, '0, "led_ones");
        add_row(OP_RD, REG_LED, '0, 32'hffff_ffff, "led_ones_rd");
        for (int k = 0; k < 4; k++) begin
            w = rand_word();
            add_row(OP_WR, REG_LED, w, '0, "led_rand");
            add_row(OP_RD, REG_LED, '0, w, "led_rand_rd");
        end
        add_row(OP_SW, '0, 32'h0002_a5a4, '0, "sw_set");  // switch 1 low
        for (int k = 0; k < 3; k++) add_row(OP_IDLE, '0, '0, '0, "sw_sync");
        add_row(OP_RD, REG_SW, '0, 32'h0002_a5a4, "sw_rd");
        add_row(OP_IRQ, '0, '0, '0, "irq_masked");
        add_row(OP_IDLE, '0, '0, '0, "irq_masked");
        add_row(OP_RD, REG_IRQ, '0, '0, "irq_masked_rd");
        add_row(OP_SW, '0, 32'h0000_0002, '0, "sw1_on");
        for (int k = 0; k < 3; k++) add_row(OP_IDLE, '0, '0, '0, "sw1_sync");
        add_row(OP_IRQ, '0, '0, '0, "irq_pulse");
        add_row(OP_RD, REG_IRQ, '0, 32'd1, "irq_set_rd");
        add_row(OP_WR, REG_IRQ, 32'd1, '0, "irq_clear");
        add_row(OP_RD, REG_IRQ, '0, '0, "irq_clear_rd");
        add_row(OP_RD, 4'd3, '0, `BOARD_BAD_RDATA, "unmapped_rd");
        add_row(OP_WR, REG_LED, 32'hcafe_f00d, '0, "led_pre_key");
        add_row(OP_KEY, '0, '0, '0, "key_reset");
        add_row(OP_RD, REG_LED, '0, '0, "key_led_rd");
        w = rand_word();
        add_row(OP_WR, REG_LED, w, '0, "led_after_key");
        add_row(OP_RD, REG_LED, '0, w, "led_after_key_rd");
    endtask

    // drive one row, strobes last a single cycle
    task automatic apply_row(input int i);
        bus_wr   = 1'b0;
        bus_rd   = 1'b0;
        irq_in   = 1'b0;
        chk_rd   = 1'b0;
        cur_name = name_tab[i];
        case (op_tab[i])
            OP_WR: begin
                bus_wr    = 1'b1;
                bus_addr  = addr_tab[i];
                bus_wdata = data_tab[i];
            end
            OP_RD: begin
                bus_rd    = 1'b1;
                bus_addr  = addr_tab[i];
                chk_rd    = 1'b1;
                exp_rdata = exp_tab[i];
            end
            OP_SW:   sw = data_tab[i][17:0];
            OP_IRQ:  irq_in = 1'b1;
            OP_KEY:  key[0] = 1'b0;  // back high after one cycle
            default: ;
        endcase
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        key       = 4'hf;
        sw        = '0;
        irq_in    = 1'b0;
        bus_wr    = 1'b0;
        bus_rd    = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        chk_rd    = 1'b0;
        exp_rdata = '0;
        cur_name  = "reset";
        lfsr      = 32'he12ce2ae;
        n_rows    = 0;
        build_table();
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        repeat (`BOARD_RST_HOLD_CYCLES + 2) @(posedge clk);  // reset stretch
        for (int i = 0; i < n_rows; i++) begin
            #1;
            apply_row(i);
            @(posedge clk);
            if (op_tab[i] == OP_KEY) begin
                #1;
                key[0] = 1'b1;
                repeat (`BOARD_RST_HOLD_CYCLES + 1) @(posedge clk);
            end
        end
        #1;
        bus_wr   = 1'b0;  // quiet bus for the tail
        bus_rd   = 1'b0;
        irq_in   = 1'b0;
        chk_rd   = 1'b0;
        cur_name = "tail";
        repeat (3) @(posedge clk);
        $display("run complete: %0d rows, %0d errors", n_rows, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog, sized from the table length
    initial begin
        #2;
        repeat (n_rows * 20 + 5 + `BOARD_RST_HOLD_CYCLES + 2) @(posedge clk);
        $display("timeout: stimulus table did not complete in time");
        $display("Errors found");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
source/board_pkg.sv
source/bus_pkg.sv
source/clk_ctrl.sv
source/io_regs.sv
source/seg7_lut_8.sv
source/soc_toplevel.sv
test/soc_checker.sv
test/tb_soc_toplevel.sv

// File: run_sim.sh
#!/bin/sh
# build and run the board I/O testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module tb_soc_toplevel
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_soc_toplevel > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    echo "FAIL"
    exit 1
fi

if ! grep -q "No errors" "$LOG"; then
    echo "FAIL: no pass line in $LOG"
    exit 1
fi

echo "PASS"
exit 0
